//--- calc_macros.svh
`ifndef CALC_MACROS_SVH
`define CALC_MACROS_SVH

// Keypad rows and keypad columns
`define KEY_LINES 4

// One decimal operand digit
`define OPERAND_W 4

// Result magnitude up to 9 + 9
`define RESULT_W 5

`endif

//--- keypad_pkg.sv
package keypad_pkg;

    // Digits keep their numeric value so the low bits are the operand
    typedef enum logic [3:0] {
        KEY_0     = 4'd0,
        KEY_1     = 4'd1,
        KEY_2     = 4'd2,
        KEY_3     = 4'd3,
        KEY_4     = 4'd4,
        KEY_5     = 4'd5,
        KEY_6     = 4'd6,
        KEY_7     = 4'd7,
        KEY_8     = 4'd8,
        KEY_9     = 4'd9,
        KEY_PLUS  = 4'd10,
        KEY_MINUS = 4'd11,
        KEY_EQ    = 4'd12,
        KEY_CLR   = 4'd13,
        KEY_X     = 4'd14,
        KEY_Y     = 4'd15
    } key_code_t;

    typedef enum logic [1:0] {
        OP_NONE = 2'd0,
        OP_ADD  = 2'd1,
        OP_SUB  = 2'd2
    } calc_op_t;

endpackage

//--- display_pkg.sv
package display_pkg;

    // Numerals 0 to 9 plus two symbols
    typedef logic [3:0] digit_code_t;

    localparam digit_code_t DIGIT_BLANK = 4'd10;
    localparam digit_code_t DIGIT_MINUS = 4'd11;

    // Active high segments with bit 6 as g and bit 0 as a
    function automatic logic [6:0] seg_pattern(input digit_code_t code);
        logic [6:0] seg;
        case (code)
            4'd0:        seg = 7'b0111111;
            4'd1:        seg = 7'b0000110;
            4'd2:        seg = 7'b1011011;
            4'd3:        seg = 7'b1001111;
            4'd4:        seg = 7'b1100110;
            4'd5:        seg = 7'b1101101;
            4'd6:        seg = 7'b1111101;
            4'd7:        seg = 7'b0000111;
            4'd8:        seg = 7'b1111111;
            4'd9:        seg = 7'b1101111;
            DIGIT_MINUS: seg = 7'b1000000; // Middle bar only
            default:     seg = 7'b0000000;
        endcase
        return seg;
    endfunction

endpackage

//--- calc_result_if.sv
`include "calc_macros.svh"

interface calc_result_if;

    logic                 valid;
    logic                 ready;
    logic [`RESULT_W-1:0] magnitude;
    logic                 negative;
    logic                 blank_tens; // Tens position shows nothing

    modport engine (
        output valid,
        output magnitude,
        output negative,
        output blank_tens,
        input  ready
    );

    modport formatter (
        input  valid,
        input  magnitude,
        input  negative,
        input  blank_tens,
        output ready
    );

endinterface

//--- keypad_scanner.sv
`include "calc_macros.svh"

module keypad_scanner import keypad_pkg::*; (
    input  logic                  clk_100Hz,
    input  logic                  reset_in,
    input  logic [`KEY_LINES-1:0] key_row,
    output logic [`KEY_LINES-1:0] key_col,
    output logic                  key_valid,
    input  logic                  key_ready,
    output key_code_t             key_code
);
    localparam int IDX_W = $clog2(`KEY_LINES);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`KEY_LINES - 1);

    logic [IDX_W-1:0] col_idx;
    logic [IDX_W-1:0] row_idx;
    logic             row_hit;
    logic             cand_valid;
    logic [IDX_W-1:0] cand_row;
    logic [IDX_W-1:0] cand_col;
    logic [IDX_W-1:0] quiet_cnt;
    logic             armed;
    logic             confirm;

    // Keypad layout with rows down and columns across
    function automatic key_code_t key_at(input logic [IDX_W-1:0] row,
                                         input logic [IDX_W-1:0] col);
        key_code_t code;
        case ({col, row})
            4'h0:    code = KEY_1;
            4'h1:    code = KEY_2;
            4'h2:    code = KEY_3;
            4'h4:    code = KEY_4;
            4'h5:    code = KEY_5;
            4'h6:    code = KEY_6;
            4'h7:    code = KEY_Y;
            4'h8:    code = KEY_7;
            4'h9:    code = KEY_8;
            4'hA:    code = KEY_9;
            4'hB:    code = KEY_CLR;
            4'hC:    code = KEY_0;
            4'hD:    code = KEY_PLUS;
            4'hE:    code = KEY_MINUS;
            4'hF:    code = KEY_EQ;
            default: code = KEY_X;
        endcase
        return code;
    endfunction

    assign key_col = {{(`KEY_LINES - 1){1'b0}}, 1'b1} << col_idx;

    // Lowest pressed row wins when several rows are active
    always_comb begin
        row_hit = |key_row;
        row_idx = '0;
        for (int r = `KEY_LINES - 1; r >= 0; r--) begin
            if (key_row[r]) begin
                row_idx = IDX_W'(r);
            end
        end
    end

    assign confirm = row_hit && cand_valid && armed && !key_valid
                  && cand_col == col_idx && cand_row == row_idx;

    always_ff @(posedge clk_100Hz or negedge reset_in) begin
        if (!reset_in) begin
            col_idx    <= '0;
            cand_valid <= 1'b0;
            quiet_cnt  <= '0;
            armed      <= 1'b1;
            key_valid  <= 1'b0;
        end else begin
            col_idx <= (col_idx == LAST_IDX) ? '0 : col_idx + 1'b1;

            // A candidate is revisited only when its own column comes round again
            if (!cand_valid || cand_col == col_idx) begin
                cand_valid <= row_hit && armed && !confirm;
            end

            if (row_hit) begin
                quiet_cnt <= '0;
            end else if (quiet_cnt != LAST_IDX) begin
                quiet_cnt <= quiet_cnt + 1'b1;
            end

            if (confirm) begin
                armed <= 1'b0;
            end else if (!row_hit && quiet_cnt == LAST_IDX) begin
                armed <= 1'b1; // Whole scan came back empty
            end

            if (confirm) begin
                key_valid <= 1'b1;
            end else if (key_ready) begin
                key_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_100Hz) begin
        if (!cand_valid || cand_col == col_idx) begin
            cand_row <= row_idx;
            cand_col <= col_idx;
        end
        if (confirm) begin
            key_code <= key_at(row_idx, col_idx);
        end
    end

endmodule

//--- calc_engine.sv
`include "calc_macros.svh"

module calc_engine import keypad_pkg::*; (
    input  logic          clk_100Hz,
    input  logic          reset_in,
    input  logic          key_valid,
    output logic          key_ready,
    input  key_code_t     key_code,
    calc_result_if.engine result
);
    typedef enum logic [1:0] {
        WAIT_A = 2'd0,
        HAVE_A = 2'd1,
        WAIT_B = 2'd2,
        HAVE_B = 2'd3
    } phase_t;

    phase_t                state;
    calc_op_t              op;
    logic [`OPERAND_W-1:0] operand_a;
    logic [`OPERAND_W-1:0] operand_b;
    logic [`OPERAND_W-1:0] digit;
    logic [`RESULT_W-1:0]  res_mag;
    logic [`RESULT_W-1:0]  calc_mag;
    logic                  res_valid;
    logic                  res_neg;
    logic                  calc_neg;
    logic                  accept;
    logic                  load_digit;
    logic                  load_calc;
    logic                  load_clear;

    // Stall the keypad while a result is still waiting to be taken
    assign key_ready = !(res_valid && !result.ready);
    assign accept    = key_valid && key_ready;
    assign digit     = `OPERAND_W'(key_code);

    assign load_digit = accept && key_code <= KEY_9 && (state == WAIT_A || state == WAIT_B);
    assign load_calc  = accept && key_code == KEY_EQ && state == HAVE_B;
    assign load_clear = accept && key_code == KEY_CLR;

    always_comb begin
        calc_neg = 1'b0;
        if (op == OP_SUB) begin
            if (operand_a < operand_b) begin
                calc_mag = `RESULT_W'(operand_b - operand_a);
                calc_neg = 1'b1;
            end else begin
                calc_mag = `RESULT_W'(operand_a - operand_b);
            end
        end else begin
            calc_mag = `RESULT_W'(operand_a) + `RESULT_W'(operand_b);
        end
    end

    always_ff @(posedge clk_100Hz or negedge reset_in) begin
        if (!reset_in) begin
            state     <= WAIT_A;
            op        <= OP_NONE;
            res_valid <= 1'b0;
        end else begin
            if (load_digit || load_calc || load_clear) begin
                res_valid <= 1'b1;
            end else if (result.ready) begin
                res_valid <= 1'b0;
            end

            if (accept) begin
                if (key_code == KEY_CLR) begin
                    state <= WAIT_A;
                    op    <= OP_NONE;
                end else begin
                    case (state)
                        WAIT_A: if (key_code <= KEY_9) state <= HAVE_A;
                        HAVE_A: begin
                            if (key_code == KEY_PLUS) begin
                                op    <= OP_ADD;
                                state <= WAIT_B;
                            end else if (key_code == KEY_MINUS) begin
                                op    <= OP_SUB;
                                state <= WAIT_B;
                            end
                        end
                        WAIT_B: if (key_code <= KEY_9) state <= HAVE_B;
                        HAVE_B: begin
                            if (key_code == KEY_EQ) begin
                                op    <= OP_NONE;
                                state <= WAIT_A;
                            end
                        end
                        default: state <= WAIT_A;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk_100Hz) begin
        if (load_clear) begin
            operand_a <= '0;
            operand_b <= '0;
            res_mag   <= '0;
            res_neg   <= 1'b0;
        end else if (load_digit) begin
            if (state == WAIT_A) begin
                operand_a <= digit;
            end else begin
                operand_b <= digit;
            end
            res_mag <= `RESULT_W'(digit); // Echo the digit as it is entered
            res_neg <= 1'b0;
        end else if (load_calc) begin
            res_mag <= calc_mag;
            res_neg <= calc_neg;
        end
    end

    assign result.valid      = res_valid;
    assign result.magnitude  = res_mag;
    assign result.negative   = res_neg;
    assign result.blank_tens = res_mag < `RESULT_W'(10);

endmodule

//--- display_formatter.sv
`include "calc_macros.svh"

module display_formatter import display_pkg::*; (
    input  logic             clk_100Hz,
    input  logic             reset_in,
    calc_result_if.formatter result,
    output digit_code_t      disp_sign,
    output digit_code_t      disp_tens,
    output digit_code_t      disp_units,
    output logic [6:0]       seg_sign,
    output logic [6:0]       seg_tens,
    output logic [6:0]       seg_units
);
    logic [`RESULT_W-1:0] tens_val;
    logic [`RESULT_W-1:0] units_val;
    digit_code_t          next_sign;
    digit_code_t          next_tens;
    digit_code_t          next_units;
    logic                 take;

    assign result.ready = 1'b1; // Display registers accept every result
    assign take         = result.valid && result.ready;

    always_comb begin
        tens_val   = result.magnitude / `RESULT_W'(10);
        units_val  = result.magnitude % `RESULT_W'(10);
        next_units = digit_code_t'(units_val);
        next_tens  = result.blank_tens ? DIGIT_BLANK : digit_code_t'(tens_val);
        next_sign  = result.negative ? DIGIT_MINUS : DIGIT_BLANK;
    end

    // Idle display reads as a single zero
    always_ff @(posedge clk_100Hz or negedge reset_in) begin
        if (!reset_in) begin
            disp_sign  <= DIGIT_BLANK;
            disp_tens  <= DIGIT_BLANK;
            disp_units <= 4'd0;
            seg_sign   <= seg_pattern(DIGIT_BLANK);
            seg_tens   <= seg_pattern(DIGIT_BLANK);
            seg_units  <= seg_pattern(4'd0);
        end else if (take) begin
            disp_sign  <= next_sign;
            disp_tens  <= next_tens;
            disp_units <= next_units;
            seg_sign   <= seg_pattern(next_sign);
            seg_tens   <= seg_pattern(next_tens);
            seg_units  <= seg_pattern(next_units);
        end
    end

endmodule

//--- keypad_calc_top.sv
`include "calc_macros.svh"

module keypad_calc_top import keypad_pkg::*, display_pkg::*; (
    input  logic                  clk_100Hz,
    input  logic                  reset_in,
    input  logic [`KEY_LINES-1:0] key_row,
    output logic [`KEY_LINES-1:0] key_col,
    output digit_code_t           disp_sign,
    output digit_code_t           disp_tens,
    output digit_code_t           disp_units,
    output logic [6:0]            seg_sign,
    output logic [6:0]            seg_tens,
    output logic [6:0]            seg_units
);
    logic      key_valid;
    logic      key_ready;
    key_code_t key_code;

    calc_result_if result_if ();

    keypad_scanner keypad_scanner_i (
        .clk_100Hz (clk_100Hz),
        .reset_in  (reset_in),
        .key_row   (key_row),
        .key_col   (key_col),
        .key_valid (key_valid),
        .key_ready (key_ready),
        .key_code  (key_code)
    );

    calc_engine calc_engine_i (
        .clk_100Hz (clk_100Hz),
        .reset_in  (reset_in),
        .key_valid (key_valid),
        .key_ready (key_ready),
        .key_code  (key_code),
        .result    (result_if.engine)
    );

    display_formatter display_formatter_i (
        .clk_100Hz  (clk_100Hz),
        .reset_in   (reset_in),
        .result     (result_if.formatter),
        .disp_sign  (disp_sign),
        .disp_tens  (disp_tens),
        .disp_units (disp_units),
        .seg_sign   (seg_sign),
        .seg_tens   (seg_tens),
        .seg_units  (seg_units)
    );

endmodule

//--- tb_keypad_calc.sv
`include "calc_macros.svh"

module tb_keypad_calc;

    localparam int SHORT_HOLD = 12;
    localparam int LONG_HOLD  = 40;
    localparam int RELEASE    = 12;
    localparam int SETTLE     = 4;

    logic                  clk_100Hz;
    logic                  reset_in;
    logic [`KEY_LINES-1:0] key_row;
    logic [`KEY_LINES-1:0] key_col;
    logic [3:0]            disp_sign;
    logic [3:0]            disp_tens;
    logic [3:0]            disp_units;
    logic [6:0]            seg_sign;
    logic [6:0]            seg_tens;
    logic [6:0]            seg_units;

    logic       pressed;
    logic [1:0] press_row;
    logic [1:0] press_col;

    string       test_names[$];
    string       test_keys[$];
    logic [11:0] test_expect[$];

    int value_errors;
    int other_errors;
    int check_count;
    int cycle_count;
    int cycle_limit;
    int scan_col;

    keypad_calc_top keypad_calc_top_i (
        .clk_100Hz  (clk_100Hz),
        .reset_in   (reset_in),
        .key_row    (key_row),
        .key_col    (key_col),
        .disp_sign  (disp_sign),
        .disp_tens  (disp_tens),
        .disp_units (disp_units),
        .seg_sign   (seg_sign),
        .seg_tens   (seg_tens),
        .seg_units  (seg_units)
    );

    always #2 clk_100Hz = ~clk_100Hz;

    // A closed key connects its row to its column while that column is driven
    assign key_row = (pressed && key_col[press_col]) ? (4'b0001 << press_row) : 4'b0000;

    // Column drive walks one column per clock and starts over after the last
    always @(posedge clk_100Hz) begin
        if (!reset_in) begin
            scan_col <= 0;
        end else begin
            scan_col <= (scan_col + 1) % `KEY_LINES;
        end
    end

    always @(negedge clk_100Hz) begin
        assert (key_col === (4'b0001 << scan_col)) else begin
            value_errors++;
            $display("ERROR column_scan: key_col expected %b, actual %b",
                     4'b0001 << scan_col, key_col);
        end
    end

    // Lit segments listed by letter with bit 0 as segment a
    function automatic logic [6:0] segments_for(input logic [3:0] code);
        string      lit;
        logic [6:0] seg;
        byte        ch;
        seg = '0;
        case (code)
            4'd0:    lit = "abcdef";
            4'd1:    lit = "bc";
            4'd2:    lit = "abdeg";
            4'd3:    lit = "abcdg";
            4'd4:    lit = "bcfg";
            4'd5:    lit = "acdfg";
            4'd6:    lit = "acdefg";
            4'd7:    lit = "abc";
            4'd8:    lit = "abcdefg";
            4'd9:    lit = "abcdfg";
            4'd11:   lit = "g";
            default: lit = "";
        endcase
        for (int i = 0; i < lit.len(); i++) begin
            ch = lit.getc(i);
            seg[ch - "a"] = 1'b1;
        end
        return seg;
    endfunction

    // Keypad face read column by column with four rows in each column
    task automatic locate_key(input byte k, output logic found,
                              output logic [1:0] row, output logic [1:0] col);
        string layout;
        layout = "123X456Y789Z0+-=";
        found  = 1'b0;
        row    = '0;
        col    = '0;
        for (int i = 0; i < 16; i++) begin
            if (layout.getc(i) == k) begin
                found = 1'b1;
                row   = 2'(i % 4);
                col   = 2'(i / 4);
            end
        end
    endtask

    task automatic press_key(input byte k, input int hold);
        logic       found;
        logic [1:0] row;
        logic [1:0] col;
        locate_key(k, found, row, col);
        if (!found) begin
            $display("Key character %c in the vectors is not on the keypad", k);
            other_errors++;
            return;
        end
        @(posedge clk_100Hz);
        press_row <= row;
        press_col <= col;
        pressed   <= 1'b1;
        repeat (hold) @(posedge clk_100Hz);
        pressed <= 1'b0;
        repeat (RELEASE - 1) @(posedge clk_100Hz); // Next press starts on the following edge
    endtask

    task automatic read_vectors();
        int         fd;
        int         fields;
        string      line;
        string      name;
        string      keys;
        logic [3:0] sign;
        logic [3:0] tens;
        logic [3:0] units;
        fd = $fopen("keypad_calc_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open keypad_calc_vectors.txt");
            other_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line   = "";
            fields = $fgets(line, fd);
            if (line.len() < 2 || line.getc(0) == "#") continue;
            fields = $sscanf(line, "%s %s %h %h %h", name, keys, sign, tens, units);
            if (fields != 5) begin
                $display("Vector line could not be read: %s", line);
                other_errors++;
            end else begin
                test_names.push_back(name);
                test_keys.push_back(keys);
                test_expect.push_back({sign, tens, units});
            end
        end
        $fclose(fd);
    endtask

    task automatic check_code(input string test, input string field,
                              input logic [3:0] expected, input logic [3:0] actual);
        check_count++;
        assert (actual === expected) else begin
            value_errors++;
            $display("ERROR %s: %s code expected %h, actual %h", test, field, expected, actual);
        end
    endtask

    task automatic check_segments(input string test, input string field,
                                  input logic [6:0] expected, input logic [6:0] actual);
        check_count++;
        assert (actual === expected) else begin
            value_errors++;
            $display("ERROR %s: %s segments expected %b, actual %b",
                     test, field, expected, actual);
        end
    endtask

    task automatic run_test(input int idx);
        string      keys;
        string      name;
        byte        ch;
        int         hold;
        logic [3:0] exp_sign;
        logic [3:0] exp_tens;
        logic [3:0] exp_units;
        keys = test_keys[idx];
        name = test_names[idx];
        hold = SHORT_HOLD;
        {exp_sign, exp_tens, exp_units} = test_expect[idx];
        for (int i = 0; i < keys.len(); i++) begin
            ch = keys.getc(i);
            if (ch == "L") begin
                hold = LONG_HOLD; // Applies to the next key only
            end else if (ch != ".") begin
                press_key(ch, hold);
                hold = SHORT_HOLD;
            end
        end
        repeat (SETTLE) @(posedge clk_100Hz);
        @(negedge clk_100Hz);
        check_code(name, "sign", exp_sign, disp_sign);
        check_code(name, "tens", exp_tens, disp_tens);
        check_code(name, "units", exp_units, disp_units);
        check_segments(name, "sign", segments_for(exp_sign), seg_sign);
        check_segments(name, "tens", segments_for(exp_tens), seg_tens);
        check_segments(name, "units", segments_for(exp_units), seg_units);
    endtask

    // Run limit grows with the number of key presses in the vectors
    always @(posedge clk_100Hz) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("Checks: %0d, value errors: %0d, other errors: %0d",
                     check_count, value_errors, other_errors + 1);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        int total_keys;
        clk_100Hz    = 1'b0;
        reset_in     = 1'b0;
        pressed      = 1'b0;
        press_row    = '0;
        press_col    = '0;
        value_errors = 0;
        other_errors = 0;
        check_count  = 0;
        cycle_count  = 0;
        total_keys   = 0;
        read_vectors();
        foreach (test_keys[t]) begin
            for (int i = 0; i < test_keys[t].len(); i++) begin
                if (test_keys[t].getc(i) != "." && test_keys[t].getc(i) != "L") total_keys++;
            end
        end
        cycle_limit = total_keys * 24 + 200;
        repeat (2) @(posedge clk_100Hz);
        reset_in <= 1'b1;
        if (test_names.size() == 0) begin
            $display("No test vectors were loaded");
            other_errors++;
        end
        foreach (test_names[t]) run_test(t);
        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 check_count, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- keypad_calc_vectors.txt
# Columns: test name, key sequence, expected sign, tens and units codes in hex
# Keys: 0-9 + - = X Y Z; L holds the next key long; a lone . means no key
reset_idle          .       a a 0
first_digit         7       a a 7
clear_after_digit   Z       a a 0
add_carry           8+5=    a 1 3
add_small           2+3=    a a 5
sub_positive        9-4=    a a 5
sub_negative        3-8=    b a 5
ignored_keys        4X+69=  a 1 0
op_before_operand   +Y5+2=  a a 7
third_digit         12+3=   a a 4
operator_holds      5+      a a 5
clear_after_op      Z       a a 0
clear_mid_entry     5-Z     a a 0
calc_after_clear    6-9=    b a 3
long_hold           L6+1=   a a 7
largest_sum         9+9=    a 1 8
equal_difference    4-4=    a a 0

//--- tb.f
+incdir+.
keypad_pkg.sv
display_pkg.sv
calc_result_if.sv
keypad_scanner.sv
calc_engine.sv
display_formatter.sv
keypad_calc_top.sv
tb_keypad_calc.sv
